// File: project.f
csr_pkg.sv
csr_counter.sv
csr_irq_ctrl.sv
csr_trap_state.sv
csr_access_ctrl.sv
csr_file.sv
tb_csr_file.sv

// File: Bender.yml
package:
  name: csr_file

sources:
  - csr_pkg.sv
  - csr_counter.sv
  - csr_irq_ctrl.sv
  - csr_trap_state.sv
  - csr_access_ctrl.sv
  - csr_file.sv
  - target: test
    files:
      - tb_csr_file.sv

// File: tb_csr_file.sv
// random-stimulus testbench with a reference model of the csr file
`timescale 1ns/100ps
`default_nettype none

module tb_csr_file;

  localparam int unsigned XLEN       = csr_pkg::XLEN;
  localparam int unsigned N_EXT_INTS = 4;
  localparam int unsigned HART_ID    = 5;
  localparam int unsigned CNT_WIDTH  = 64;
  localparam int unsigned SEED       = 32'h98a4_4387;

  // iterations per test and worst case cycles per iteration
  localparam int N_REG  = 400;
  localparam int N_ILL  = 30;
  localparam int N_TRAP = 60;
  localparam int N_IRQ  = 100;
  localparam int N_CNT  = 60;
  localparam int TEST_CYCLES = 5 + N_REG + N_ILL * 10 + N_TRAP * 14 + N_IRQ * 7 + 2 + N_CNT * 9;
  localparam int MAX_CYCLES  = 4 * TEST_CYCLES;

  logic clk, nreset, timer_tick, retire, exception, exception_int, eret;
  csr_pkg::csr_addr_t    addr;
  csr_pkg::csr_cmd_e     cmd;
  logic [XLEN-1:0]       wdata, exception_pc, interrupt_pc, exception_load_addr, exception_inst;
  logic [N_EXT_INTS-1:0] ext_interrupts;
  csr_pkg::cause_t       exception_code;
  logic [XLEN-1:0]       rdata, handler_pc, mepc;
  logic                  illegal_access, interrupt_pending, interrupt_taken;
  csr_pkg::prv_t         prv;
  csr_pkg::cause_t       interrupt_code;

  // reference model state
  logic [1:0]  m_prv, m_mpp;
  logic        m_mie, m_mpie, m_exc_q, m_msip, m_mtip, m_meip;
  logic [31:0] m_mtvec, m_mscratch, m_mepc, m_mcause, m_mtval;
  logic [63:0] m_cycle, m_instret;

  int          cycle_count = 0;
  int unsigned seed_value;
  logic [11:0] sel;
  logic [31:0] status_w;

  csr_file #(.N_EXT_INTS(N_EXT_INTS), .HART_ID(HART_ID), .CNT_WIDTH(CNT_WIDTH)) i_dut (
    .clk, .nreset, .addr, .cmd, .wdata, .ext_interrupts, .timer_tick, .retire,
    .exception, .exception_code, .exception_int, .exception_pc, .interrupt_pc,
    .exception_load_addr, .exception_inst, .eret,
    .rdata, .illegal_access, .prv, .handler_pc, .mepc,
    .interrupt_pending, .interrupt_taken, .interrupt_code
  );

  always #20 clk = ~clk;   // 40 ns period

  always @(posedge clk) begin
    cycle_count++;
    if (cycle_count >= MAX_CYCLES) begin
      $display("Run stopped: no result after %0d cycles", MAX_CYCLES);
      $display("=== FAIL ===");
      $fatal(1, "timeout");
    end
  end

  task automatic check_value(input string name, input logic [63:0] actual,
                             input logic [63:0] expected);
    if (actual !== expected) begin
      $display("Mismatch at %0t: %s actual %h expected %h", $time, name, actual, expected);
      $display("=== FAIL ===");
      $fatal(1, "stopped at first check failure");
    end
  endtask

  // ============================================================
  // reference model
  // ============================================================
  function automatic logic [31:0] model_read(input logic [11:0] a, output logic def);
    logic [31:0] v;
    v   = '0;
    def = 1'b1;
    case (a)
      csr_pkg::ADDR_MSTATUS:   v = {19'd0, m_mpp, 3'd0, m_mpie, 3'd0, m_mie, 3'd0};
      csr_pkg::ADDR_MISA:      v = csr_pkg::MISA_VALUE;
      csr_pkg::ADDR_MIE:       v = '0;
      csr_pkg::ADDR_MTVEC:     v = m_mtvec;
      csr_pkg::ADDR_MSCRATCH:  v = m_mscratch;
      csr_pkg::ADDR_MEPC:      v = m_mepc;
      csr_pkg::ADDR_MCAUSE:    v = m_mcause;
      csr_pkg::ADDR_MTVAL:     v = m_mtval;
      csr_pkg::ADDR_MIP:       v = {20'd0, m_meip, 3'd0, m_mtip, 3'd0, m_msip, 3'd0};
      csr_pkg::ADDR_MCYCLE, csr_pkg::ADDR_CYCLE:       v = m_cycle[31:0];
      csr_pkg::ADDR_MCYCLEH, csr_pkg::ADDR_CYCLEH:     v = m_cycle[63:32];
      csr_pkg::ADDR_MINSTRET, csr_pkg::ADDR_INSTRET:   v = m_instret[31:0];
      csr_pkg::ADDR_MINSTRETH, csr_pkg::ADDR_INSTRETH: v = m_instret[63:32];
      csr_pkg::ADDR_MVENDORID: v = csr_pkg::VENDOR_ID;
      csr_pkg::ADDR_MARCHID:   v = csr_pkg::ARCH_ID;
      csr_pkg::ADDR_MIMPID:    v = csr_pkg::IMPL_ID;
      csr_pkg::ADDR_MHARTID:   v = HART_ID;
      default:                 def = 1'b0;
    endcase
    return v;
  endfunction

  function automatic logic model_illegal(input logic [2:0] c, input logic [11:0] a);
    logic        def;
    logic [31:0] v;
    v = model_read(a, def);
    return c[2] && (!def || ((c[1:0] != 2'b00) && (a[11:10] == 2'b11)) || (a[9:8] > m_prv));
  endfunction

  task automatic update_model();
    logic        def;
    logic        we;
    logic        trap;
    logic [31:0] cur;
    logic [31:0] wd;
    cur  = model_read(addr, def);
    we   = cmd[2] && (cmd[1:0] != 2'b00) && !model_illegal(cmd, addr);
    wd   = (cmd == csr_pkg::CSR_SET) ? (cur | wdata)
         : (cmd == csr_pkg::CSR_CLEAR) ? (cur & ~wdata) : wdata;
    trap = exception && !m_exc_q;   // rising edge only
    if (we && addr == csr_pkg::ADDR_MSTATUS) begin
      if (wd[12:11] == 2'd0 || wd[12:11] == 2'd3) m_mpp = wd[12:11];
      m_mpie = wd[7];
      m_mie  = wd[3];
    end else if (trap) begin
      m_mpp  = m_prv;
      m_prv  = csr_pkg::PRV_M;
      m_mpie = m_mie;
      m_mie  = 1'b0;
    end else if (eret) begin
      m_prv  = m_mpp;
      m_mpp  = csr_pkg::PRV_M;
      m_mie  = m_mpie;
      m_mpie = 1'b1;
    end
    if (we && addr == csr_pkg::ADDR_MTVEC) m_mtvec = {wd[31:2], 2'b00};
    if (we && addr == csr_pkg::ADDR_MSCRATCH) m_mscratch = wd;
    if (we && addr == csr_pkg::ADDR_MEPC) m_mepc = wd;
    else if (trap) m_mepc = (exception_int ? interrupt_pc : exception_pc) & ~32'd1;
    if (we && addr == csr_pkg::ADDR_MCAUSE) m_mcause = wd;
    else if (trap) m_mcause = {exception_int, 27'd0, exception_code};
    if (we && addr == csr_pkg::ADDR_MTVAL) begin
      m_mtval = wd;
    end else if (trap && !exception_int) begin
      case (exception_code)
        csr_pkg::CAUSE_INST_MISALIGNED, csr_pkg::CAUSE_INST_FAULT: m_mtval = exception_pc;
        csr_pkg::CAUSE_ILLEGAL_INST: m_mtval = exception_inst;
        csr_pkg::CAUSE_LOAD_MISALIGNED, csr_pkg::CAUSE_LOAD_FAULT,
        csr_pkg::CAUSE_STORE_MISALIGNED, csr_pkg::CAUSE_STORE_FAULT: m_mtval = exception_load_addr;
        default: ;   // other codes keep mtval
      endcase
    end
    if (we && addr == csr_pkg::ADDR_MIP) begin
      m_msip = wd[3];
    end else begin
      m_mtip = timer_tick;
      m_meip = |ext_interrupts;
    end
    if (we && addr == csr_pkg::ADDR_MCYCLE) m_cycle[31:0] = wd;
    else if (we && addr == csr_pkg::ADDR_MCYCLEH) m_cycle[63:32] = wd;
    else m_cycle = m_cycle + 64'd1;
    if (we && addr == csr_pkg::ADDR_MINSTRET) m_instret[31:0] = wd;
    else if (we && addr == csr_pkg::ADDR_MINSTRETH) m_instret[63:32] = wd;
    else if (retire) m_instret = m_instret + 64'd1;
    m_exc_q = exception;
  endtask

  // ============================================================
  // stimulus and checks
  // ============================================================
  task automatic check_outputs();
    logic        def;
    logic        ill;
    logic        pend;
    logic [31:0] exp_rd;
    exp_rd = model_read(addr, def);
    ill    = model_illegal(cmd, addr);
    pend   = m_msip || m_mtip || m_meip;
    check_value("illegal_access", illegal_access, ill);
    if (cmd[2] && !ill) check_value("rdata", rdata, exp_rd);
    check_value("prv", prv, m_prv);
    check_value("handler_pc", handler_pc, m_mtvec);
    check_value("mepc", mepc, m_mepc);
    check_value("interrupt_pending", interrupt_pending, pend);
    check_value("interrupt_taken", interrupt_taken, pend && (m_prv == csr_pkg::PRV_U || m_mie));
    if (pend) begin
      check_value("interrupt_code", interrupt_code, m_mtip ? csr_pkg::CAUSE_MTIMER_INT
                  : m_meip ? csr_pkg::CAUSE_MEXT_INT : csr_pkg::CAUSE_MSOFT_INT);
    end
  endtask

  // entered on a falling edge and returns on the next one
  task automatic cycle_step();
    timer_tick     = ($urandom % 3) == 0;
    ext_interrupts = (($urandom % 4) == 0) ? N_EXT_INTS'($urandom) : '0;
    retire         = 1'($urandom % 2);
    #1;
    check_outputs();
    @(posedge clk);
    update_model();
    @(negedge clk);
    cmd  = csr_pkg::CSR_IDLE;
    eret = 1'b0;
  endtask

  task automatic csr_op(input csr_pkg::csr_cmd_e c, input logic [11:0] a, input logic [31:0] d);
    cmd   = c;
    addr  = a;
    wdata = d;
    cycle_step();
  endtask

  task automatic pulse_eret();
    eret = 1'b1;
    cycle_step();
  endtask

  task automatic take_trap(input int unsigned hold);
    exception_int       = ($urandom % 4) == 0;
    exception_code      = 4'($urandom % 12);
    exception_pc        = $urandom;
    interrupt_pc        = $urandom;
    exception_load_addr = $urandom;
    exception_inst      = $urandom;
    exception           = 1'b1;
    repeat (hold) cycle_step();   // held exception must trap once
    exception = 1'b0;
    cycle_step();
  endtask

  task automatic enter_machine();
    if (m_prv != csr_pkg::PRV_M) take_trap(1);
  endtask

  function automatic csr_pkg::csr_cmd_e random_cmd(input logic writes_only);
    int unsigned r;
    r = writes_only ? 1 + $urandom % 3 : $urandom % 4;
    case (r)
      0:       return csr_pkg::CSR_READ;
      1:       return csr_pkg::CSR_WRITE;
      2:       return csr_pkg::CSR_SET;
      default: return csr_pkg::CSR_CLEAR;
    endcase
  endfunction

  // 0-4 trap regs, 5-9 identification, 10-13 machine counters, 14-17 user counters
  function automatic logic [11:0] addr_from_table(input int unsigned i);
    case (i)
      0:  return csr_pkg::ADDR_MSCRATCH;
      1:  return csr_pkg::ADDR_MTVEC;
      2:  return csr_pkg::ADDR_MEPC;
      3:  return csr_pkg::ADDR_MCAUSE;
      4:  return csr_pkg::ADDR_MTVAL;
      5:  return csr_pkg::ADDR_MISA;
      6:  return csr_pkg::ADDR_MVENDORID;
      7:  return csr_pkg::ADDR_MARCHID;
      8:  return csr_pkg::ADDR_MIMPID;
      9:  return csr_pkg::ADDR_MHARTID;
      10: return csr_pkg::ADDR_MCYCLE;
      11: return csr_pkg::ADDR_MCYCLEH;
      12: return csr_pkg::ADDR_MINSTRET;
      13: return csr_pkg::ADDR_MINSTRETH;
      14: return csr_pkg::ADDR_CYCLE;
      15: return csr_pkg::ADDR_CYCLEH;
      16: return csr_pkg::ADDR_INSTRET;
      default: return csr_pkg::ADDR_INSTRETH;
    endcase
  endfunction

  function automatic logic [11:0] undefined_addr();
    logic [11:0] a;
    logic        def;
    logic [31:0] v;
    do begin
      a = 12'($urandom);
      v = model_read(a, def);
    end while (def);
    return a;
  endfunction

  initial begin
    seed_value = $urandom(SEED);
    clk = 1'b0;
    nreset = 1'b0;
    cmd = csr_pkg::CSR_IDLE;
    addr = '0;
    wdata = '0;
    ext_interrupts = '0;
    timer_tick = 1'b0;
    retire = 1'b0;
    exception = 1'b0;
    exception_code = '0;
    exception_int = 1'b0;
    exception_pc = '0;
    interrupt_pc = '0;
    exception_load_addr = '0;
    exception_inst = '0;
    eret = 1'b0;
    m_prv = csr_pkg::PRV_M;
    m_mpp = csr_pkg::PRV_U;
    {m_mie, m_mpie, m_exc_q, m_msip, m_mtip, m_meip} = '0;
    m_mtvec = csr_pkg::MTVEC_RESET;
    {m_mscratch, m_mepc, m_mcause, m_mtval} = '0;
    m_cycle = '0;
    m_instret = '0;
    repeat (4) @(posedge clk);
    @(negedge clk);
    nreset = 1'b1;

    // register access
    repeat (N_REG) csr_op(random_cmd(1'b0), addr_from_table($urandom % 5), $urandom);

    // illegal access and reread from machine mode
    repeat (N_ILL) begin
      csr_op(random_cmd(1'b1), addr_from_table(5 + $urandom % 5), $urandom);
      csr_op(csr_pkg::CSR_READ, addr_from_table(5 + $urandom % 5), '0);
      csr_op(random_cmd(1'b0), undefined_addr(), $urandom);
      csr_op(csr_pkg::CSR_WRITE, csr_pkg::ADDR_MSTATUS, '0);   // mpp user
      pulse_eret();
      sel = addr_from_table($urandom % 14);
      csr_op(random_cmd(1'b0), sel, $urandom);
      csr_op(csr_pkg::CSR_READ, addr_from_table(14 + $urandom % 4), '0);
      take_trap(1);
      csr_op(csr_pkg::CSR_READ, sel, '0);
    end

    // trap entry and return
    repeat (N_TRAP) begin
      if ($urandom % 2) begin
        csr_op(csr_pkg::CSR_WRITE, csr_pkg::ADDR_MSTATUS, $urandom);
        pulse_eret();
      end
      take_trap(1 + $urandom % 4);
      csr_op(csr_pkg::CSR_READ, csr_pkg::ADDR_MEPC, '0);
      csr_op(csr_pkg::CSR_READ, csr_pkg::ADDR_MCAUSE, '0);
      csr_op(csr_pkg::CSR_READ, csr_pkg::ADDR_MTVAL, '0);
      csr_op(csr_pkg::CSR_READ, csr_pkg::ADDR_MSTATUS, '0);
      pulse_eret();
      csr_op(csr_pkg::CSR_READ, csr_pkg::ADDR_MSTATUS, '0);
      if (($urandom % 4) == 0) csr_op(csr_pkg::CSR_WRITE, csr_pkg::ADDR_MTVEC, $urandom);
    end

    // interrupts in both privilege levels with mie set and clear
    repeat (N_IRQ) begin
      enter_machine();
      status_w = '0;
      status_w[12:11] = ($urandom % 2) ? 2'd3 : 2'd0;
      status_w[7] = 1'($urandom);
      status_w[3] = 1'($urandom);
      csr_op(csr_pkg::CSR_WRITE, csr_pkg::ADDR_MSTATUS, status_w);
      if ($urandom % 2) csr_op(random_cmd(1'b1), csr_pkg::ADDR_MIP, $urandom);
      if ($urandom % 2) pulse_eret();
      repeat (2) cycle_step();
    end

    // counters
    enter_machine();
    repeat (N_CNT) begin
      if ($urandom % 2) csr_op(random_cmd(1'b1), addr_from_table(10 + $urandom % 4), $urandom);
      for (int i = 0; i < 8; i++) csr_op(csr_pkg::CSR_READ, addr_from_table(10 + i), '0);
    end

    $display("=== PASS ===");
    $finish;
  end

endmodule

`default_nettype wire

// File: csr_file.sv
// csr_file: machine mode csr file top, access control plus trap, interrupt and counter state
`timescale 1ns/100ps
`default_nettype none

module csr_file #(
  parameter int unsigned N_EXT_INTS = 4,
  parameter int unsigned HART_ID    = 0,
  parameter int unsigned CNT_WIDTH  = 64
) (
  input  wire                         clk,
  input  wire                         nreset,
  input  wire csr_pkg::csr_addr_t     addr,
  input  wire csr_pkg::csr_cmd_e      cmd,
  input  wire [csr_pkg::XLEN-1:0]     wdata,
  input  wire [N_EXT_INTS-1:0]        ext_interrupts,
  input  wire                         timer_tick,
  input  wire                         retire,
  input  wire                         exception,
  input  wire csr_pkg::cause_t        exception_code,
  input  wire                         exception_int,
  input  wire [csr_pkg::XLEN-1:0]     exception_pc,
  input  wire [csr_pkg::XLEN-1:0]     interrupt_pc,
  input  wire [csr_pkg::XLEN-1:0]     exception_load_addr,
  input  wire [csr_pkg::XLEN-1:0]     exception_inst,
  input  wire                         eret,
  output logic [csr_pkg::XLEN-1:0]    rdata,
  output logic                        illegal_access,
  output csr_pkg::prv_t               prv,
  output logic [csr_pkg::XLEN-1:0]    handler_pc,
  output logic [csr_pkg::XLEN-1:0]    mepc,
  output logic                        interrupt_pending,
  output logic                        interrupt_taken,
  output csr_pkg::cause_t             interrupt_code
);

  logic [csr_pkg::XLEN-1:0] wr_data;
  logic [csr_pkg::XLEN-1:0] mstatus_val, mtvec_val, mscratch_val;
  logic [csr_pkg::XLEN-1:0] mcause_val, mtval_val, mip_val;
  logic [CNT_WIDTH-1:0]     cycle_val, instret_val;
  logic mstatus_we, mtvec_we, mscratch_we, mepc_we, mcause_we, mtval_we, mip_we;
  logic cycle_lo_we, cycle_hi_we, instret_lo_we, instret_hi_we;

  // ==========================================================
  // access control
  // ==========================================================
  csr_access_ctrl #(.HART_ID(HART_ID), .CNT_WIDTH(CNT_WIDTH)) i_access_ctrl (
    .addr, .cmd, .wdata, .prv,
    .mstatus_val, .mtvec_val, .mscratch_val, .mepc_val(mepc),
    .mcause_val, .mtval_val, .mip_val, .cycle_val, .instret_val,
    .rdata, .illegal_access, .wr_data,
    .mstatus_we, .mtvec_we, .mscratch_we, .mepc_we, .mcause_we, .mtval_we, .mip_we,
    .cycle_lo_we, .cycle_hi_we, .instret_lo_we, .instret_hi_we
  );

  // ==========================================================
  // datapath state
  // ==========================================================
  csr_trap_state i_trap_state (
    .clk, .nreset, .wr_data,
    .mstatus_we, .mtvec_we, .mscratch_we, .mepc_we, .mcause_we, .mtval_we,
    .exception, .exception_code, .exception_int, .exception_pc, .interrupt_pc,
    .exception_load_addr, .exception_inst, .eret,
    .prv, .mstatus_val, .mtvec_val, .mscratch_val, .mepc_val(mepc),
    .mcause_val, .mtval_val, .handler_pc
  );

  csr_irq_ctrl #(.N_EXT_INTS(N_EXT_INTS)) i_irq_ctrl (
    .clk, .nreset, .wr_data, .mip_we, .ext_interrupts, .timer_tick, .prv,
    .mie_bit(mstatus_val[3]),                     // global mie from mstatus
    .mip_val, .interrupt_pending, .interrupt_taken, .interrupt_code
  );

  csr_counter #(.CNT_WIDTH(CNT_WIDTH)) i_cycle (
    .clk, .nreset, .inc(1'b1), .wr_data,
    .lo_we(cycle_lo_we), .hi_we(cycle_hi_we), .count(cycle_val)
  );

  csr_counter #(.CNT_WIDTH(CNT_WIDTH)) i_instret (
    .clk, .nreset, .inc(retire), .wr_data,
    .lo_we(instret_lo_we), .hi_we(instret_hi_we), .count(instret_val)
  );

endmodule

`default_nettype wire

// File: csr_access_ctrl.sv
// csr_access_ctrl: command decode, legality check, write data, write strobes, read mux
`timescale 1ns/100ps
`default_nettype none

module csr_access_ctrl #(
  parameter int unsigned HART_ID   = 0,
  parameter int unsigned CNT_WIDTH = 64
) (
  input  wire csr_pkg::csr_addr_t     addr,
  input  wire csr_pkg::csr_cmd_e      cmd,
  input  wire [csr_pkg::XLEN-1:0]     wdata,
  input  wire csr_pkg::prv_t          prv,
  input  wire [csr_pkg::XLEN-1:0]     mstatus_val,
  input  wire [csr_pkg::XLEN-1:0]     mtvec_val,
  input  wire [csr_pkg::XLEN-1:0]     mscratch_val,
  input  wire [csr_pkg::XLEN-1:0]     mepc_val,
  input  wire [csr_pkg::XLEN-1:0]     mcause_val,
  input  wire [csr_pkg::XLEN-1:0]     mtval_val,
  input  wire [csr_pkg::XLEN-1:0]     mip_val,
  input  wire [CNT_WIDTH-1:0]         cycle_val,
  input  wire [CNT_WIDTH-1:0]         instret_val,
  output logic [csr_pkg::XLEN-1:0]    rdata,
  output logic                        illegal_access,
  output logic [csr_pkg::XLEN-1:0]    wr_data,
  output logic                        mstatus_we,
  output logic                        mtvec_we,
  output logic                        mscratch_we,
  output logic                        mepc_we,
  output logic                        mcause_we,
  output logic                        mtval_we,
  output logic                        mip_we,
  output logic                        cycle_lo_we,
  output logic                        cycle_hi_we,
  output logic                        instret_lo_we,
  output logic                        instret_hi_we
);

  localparam int unsigned XLEN = csr_pkg::XLEN;
  localparam int unsigned CW   = 2 * XLEN;

  logic [CW-1:0] cycle_ext;              // counters padded to two full words
  logic [CW-1:0] instret_ext;
  logic          defined;
  logic          access;
  logic          write;
  logic          write_ok;

  assign cycle_ext   = CW'(cycle_val);
  assign instret_ext = CW'(instret_val);

  // ==========================================================
  // read multiplexer
  // ==========================================================
  always_comb begin
    rdata   = '0;
    defined = 1'b1;
    case (addr)
      csr_pkg::ADDR_MSTATUS:   rdata = mstatus_val;
      csr_pkg::ADDR_MISA:      rdata = csr_pkg::MISA_VALUE;
      csr_pkg::ADDR_MIE:       rdata = '0;   // only the global enable in mstatus
      csr_pkg::ADDR_MTVEC:     rdata = mtvec_val;
      csr_pkg::ADDR_MSCRATCH:  rdata = mscratch_val;
      csr_pkg::ADDR_MEPC:      rdata = mepc_val;
      csr_pkg::ADDR_MCAUSE:    rdata = mcause_val;
      csr_pkg::ADDR_MTVAL:     rdata = mtval_val;
      csr_pkg::ADDR_MIP:       rdata = mip_val;
      csr_pkg::ADDR_MCYCLE,
      csr_pkg::ADDR_CYCLE:     rdata = cycle_ext[XLEN-1:0];
      csr_pkg::ADDR_MCYCLEH,
      csr_pkg::ADDR_CYCLEH:    rdata = cycle_ext[CW-1:XLEN];
      csr_pkg::ADDR_MINSTRET,
      csr_pkg::ADDR_INSTRET:   rdata = instret_ext[XLEN-1:0];
      csr_pkg::ADDR_MINSTRETH,
      csr_pkg::ADDR_INSTRETH:  rdata = instret_ext[CW-1:XLEN];
      csr_pkg::ADDR_MVENDORID: rdata = csr_pkg::VENDOR_ID;
      csr_pkg::ADDR_MARCHID:   rdata = csr_pkg::ARCH_ID;
      csr_pkg::ADDR_MIMPID:    rdata = csr_pkg::IMPL_ID;
      csr_pkg::ADDR_MHARTID:   rdata = HART_ID;
      default:                 defined = 1'b0;
    endcase
  end

  // ==========================================================
  // legality and write path
  // ==========================================================
  assign access = cmd[2];
  assign write  = access && (cmd[1:0] != 2'b00);

  assign illegal_access = access && (!defined
                                     || (write && (addr[11:10] == 2'b11))
                                     || (addr[9:8] > prv));
  assign write_ok = write && !illegal_access;   // illegal writes leave state alone

  // set and clear are read-modify-write on the current value
  always_comb begin
    case (cmd)
      csr_pkg::CSR_SET:   wr_data = rdata | wdata;
      csr_pkg::CSR_CLEAR: wr_data = rdata & ~wdata;
      default:            wr_data = wdata;
    endcase
  end

  assign mstatus_we    = write_ok && (addr == csr_pkg::ADDR_MSTATUS);
  assign mtvec_we      = write_ok && (addr == csr_pkg::ADDR_MTVEC);
  assign mscratch_we   = write_ok && (addr == csr_pkg::ADDR_MSCRATCH);
  assign mepc_we       = write_ok && (addr == csr_pkg::ADDR_MEPC);
  assign mcause_we     = write_ok && (addr == csr_pkg::ADDR_MCAUSE);
  assign mtval_we      = write_ok && (addr == csr_pkg::ADDR_MTVAL);
  assign mip_we        = write_ok && (addr == csr_pkg::ADDR_MIP);
  assign cycle_lo_we   = write_ok && (addr == csr_pkg::ADDR_MCYCLE);
  assign cycle_hi_we   = write_ok && (addr == csr_pkg::ADDR_MCYCLEH);
  assign instret_lo_we = write_ok && (addr == csr_pkg::ADDR_MINSTRET);
  assign instret_hi_we = write_ok && (addr == csr_pkg::ADDR_MINSTRETH);

endmodule

`default_nettype wire

// File: csr_trap_state.sv
// csr_trap_state: privilege stack, mtvec, mscratch, mepc, mcause, mtval, trap edge detect
`timescale 1ns/100ps
`default_nettype none

module csr_trap_state (
  input  wire                         clk,
  input  wire                         nreset,
  input  wire [csr_pkg::XLEN-1:0]     wr_data,
  input  wire                         mstatus_we,
  input  wire                         mtvec_we,
  input  wire                         mscratch_we,
  input  wire                         mepc_we,
  input  wire                         mcause_we,
  input  wire                         mtval_we,
  input  wire                         exception,
  input  wire csr_pkg::cause_t        exception_code,
  input  wire                         exception_int,
  input  wire [csr_pkg::XLEN-1:0]     exception_pc,
  input  wire [csr_pkg::XLEN-1:0]     interrupt_pc,
  input  wire [csr_pkg::XLEN-1:0]     exception_load_addr,
  input  wire [csr_pkg::XLEN-1:0]     exception_inst,
  input  wire                         eret,
  output csr_pkg::prv_t               prv,
  output logic [csr_pkg::XLEN-1:0]    mstatus_val,
  output logic [csr_pkg::XLEN-1:0]    mtvec_val,
  output logic [csr_pkg::XLEN-1:0]    mscratch_val,
  output logic [csr_pkg::XLEN-1:0]    mepc_val,
  output logic [csr_pkg::XLEN-1:0]    mcause_val,
  output logic [csr_pkg::XLEN-1:0]    mtval_val,
  output logic [csr_pkg::XLEN-1:0]    handler_pc
);

  csr_pkg::prv_t            mpp;
  logic                     mpie;
  logic                     mie;
  logic                     exception_q;
  logic                     trap;
  logic                     tval_upd;     // this code records a trap value
  logic [csr_pkg::XLEN-1:0] tval_sel;

  // a held exception traps once, on its first cycle
  always_ff @(posedge clk or negedge nreset) begin
    if (!nreset) begin
      exception_q <= 1'b0;
    end else begin
      exception_q <= exception;
    end
  end

  assign trap = exception && !exception_q;

  // ==========================================================
  // privilege stack, write beats trap beats eret
  // ==========================================================
  always_ff @(posedge clk or negedge nreset) begin
    if (!nreset) begin
      prv  <= csr_pkg::PRV_M;
      mpp  <= csr_pkg::PRV_U;
      mpie <= 1'b0;
      mie  <= 1'b0;
    end else if (mstatus_we) begin
      if ((wr_data[12:11] == csr_pkg::PRV_U) || (wr_data[12:11] == csr_pkg::PRV_M)) begin
        mpp <= wr_data[12:11];              // other encodings are not supported
      end
      mpie <= wr_data[7];
      mie  <= wr_data[3];
    end else if (trap) begin
      prv  <= csr_pkg::PRV_M;
      mpp  <= prv;
      mpie <= mie;
      mie  <= 1'b0;
    end else if (eret) begin
      prv  <= mpp;
      mpp  <= csr_pkg::PRV_M;
      mpie <= 1'b1;
      mie  <= mpie;
    end
  end

  assign mstatus_val = {19'd0, mpp, 3'd0, mpie, 3'd0, mie, 3'd0};

  always_comb begin
    tval_upd = 1'b1;
    tval_sel = exception_pc;
    case (exception_code)
      csr_pkg::CAUSE_INST_MISALIGNED,
      csr_pkg::CAUSE_INST_FAULT:       tval_sel = exception_pc;
      csr_pkg::CAUSE_LOAD_MISALIGNED,
      csr_pkg::CAUSE_LOAD_FAULT,
      csr_pkg::CAUSE_STORE_MISALIGNED,
      csr_pkg::CAUSE_STORE_FAULT:      tval_sel = exception_load_addr;
      csr_pkg::CAUSE_ILLEGAL_INST:     tval_sel = exception_inst;
      default:                         tval_upd = 1'b0;
    endcase
  end

  // ==========================================================
  // trap registers
  // ==========================================================
  always_ff @(posedge clk or negedge nreset) begin
    if (!nreset) begin
      mtvec_val    <= csr_pkg::MTVEC_RESET;
      mscratch_val <= '0;
      mepc_val     <= '0;
      mcause_val   <= '0;
      mtval_val    <= '0;
    end else begin
      if (mtvec_we) mtvec_val <= {wr_data[31:2], 2'b00};    // direct mode only
      if (mscratch_we) mscratch_val <= wr_data;
      if (mepc_we) begin
        mepc_val <= wr_data;
      end else if (trap) begin
        mepc_val <= exception_int ? {interrupt_pc[31:1], 1'b0} : {exception_pc[31:1], 1'b0};
      end
      if (mcause_we) begin
        mcause_val <= wr_data;
      end else if (trap) begin
        mcause_val <= {exception_int, 27'd0, exception_code};
      end
      if (mtval_we) begin
        mtval_val <= wr_data;
      end else if (trap && !exception_int && tval_upd) begin
        mtval_val <= tval_sel;
      end
    end
  end

  assign handler_pc = mtvec_val;

endmodule

`default_nettype wire

// File: csr_irq_ctrl.sv
// csr_irq_ctrl: mip register, interrupt pending, taken and cause code
`timescale 1ns/100ps
`default_nettype none

module csr_irq_ctrl #(
  parameter int unsigned N_EXT_INTS = 4
) (
  input  wire                         clk,
  input  wire                         nreset,
  input  wire [csr_pkg::XLEN-1:0]     wr_data,
  input  wire                         mip_we,
  input  wire [N_EXT_INTS-1:0]        ext_interrupts,
  input  wire                         timer_tick,
  input  wire csr_pkg::prv_t          prv,
  input  wire                         mie_bit,
  output logic [csr_pkg::XLEN-1:0]    mip_val,
  output logic                        interrupt_pending,
  output logic                        interrupt_taken,
  output csr_pkg::cause_t             interrupt_code
);

  logic msip;   // software, written by the core
  logic mtip;   // timer
  logic meip;   // any external line

  // the sampled lines hold while software writes mip
  always_ff @(posedge clk or negedge nreset) begin
    if (!nreset) begin
      msip <= 1'b0;
      mtip <= 1'b0;
      meip <= 1'b0;
    end else if (mip_we) begin
      msip <= wr_data[3];
    end else begin
      mtip <= timer_tick;
      meip <= |ext_interrupts;
    end
  end

  assign mip_val = {20'd0, meip, 3'd0, mtip, 3'd0, msip, 3'd0};

  assign interrupt_pending = msip || mtip || meip;
  // user mode cannot mask machine interrupts
  assign interrupt_taken   = interrupt_pending && ((prv == csr_pkg::PRV_U) || mie_bit);

  always_comb begin
    if (mtip)      interrupt_code = csr_pkg::CAUSE_MTIMER_INT;
    else if (meip) interrupt_code = csr_pkg::CAUSE_MEXT_INT;
    else           interrupt_code = csr_pkg::CAUSE_MSOFT_INT;
  end

endmodule

`default_nettype wire

// File: csr_counter.sv
// csr_counter: event counter with word-wide half writes
`timescale 1ns/100ps
`default_nettype none

module csr_counter #(
  parameter int unsigned CNT_WIDTH = 64   // 33 to 64
) (
  input  wire                         clk,
  input  wire                         nreset,
  input  wire                         inc,
  input  wire [csr_pkg::XLEN-1:0]     wr_data,
  input  wire                         lo_we,
  input  wire                         hi_we,
  output logic [CNT_WIDTH-1:0]        count
);

  localparam int unsigned XLEN = csr_pkg::XLEN;
  localparam int unsigned HI_W = CNT_WIDTH - XLEN;

  // a half write replaces the count for that cycle
  always_ff @(posedge clk or negedge nreset) begin
    if (!nreset) begin
      count <= '0;
    end else if (lo_we) begin
      count[XLEN-1:0] <= wr_data;
    end else if (hi_we) begin
      count[CNT_WIDTH-1:XLEN] <= wr_data[HI_W-1:0];   // upper data bits dropped
    end else if (inc) begin
      count <= count + CNT_WIDTH'(1);
    end
  end

endmodule

`default_nettype wire

// File: csr_pkg.sv
// shared widths, command encoding, privilege levels, cause codes, csr addresses, reset values
`default_nettype none

package csr_pkg;

  localparam int unsigned XLEN = 32;

  typedef logic [11:0] csr_addr_t;       // 11:10 == 3 read-only, 9:8 min privilege

  // bit 2 marks an access, nonzero 1:0 marks a write
  typedef enum logic [2:0] {
    CSR_IDLE  = 3'd0,
    CSR_READ  = 3'd4,
    CSR_WRITE = 3'd5,
    CSR_SET   = 3'd6,
    CSR_CLEAR = 3'd7
  } csr_cmd_e;

  typedef logic [1:0] prv_t;
  localparam prv_t PRV_U = 2'd0;
  localparam prv_t PRV_M = 2'd3;

  // synchronous and interrupt codes share the value space
  typedef logic [3:0] cause_t;
  localparam cause_t CAUSE_INST_MISALIGNED  = 4'd0;
  localparam cause_t CAUSE_INST_FAULT       = 4'd1;
  localparam cause_t CAUSE_ILLEGAL_INST     = 4'd2;
  localparam cause_t CAUSE_LOAD_MISALIGNED  = 4'd4;
  localparam cause_t CAUSE_LOAD_FAULT       = 4'd5;
  localparam cause_t CAUSE_STORE_MISALIGNED = 4'd6;
  localparam cause_t CAUSE_STORE_FAULT      = 4'd7;
  localparam cause_t CAUSE_MSOFT_INT        = 4'd3;
  localparam cause_t CAUSE_MTIMER_INT       = 4'd7;
  localparam cause_t CAUSE_MEXT_INT         = 4'd11;

  // ==========================================================
  // machine mode csr map
  // ==========================================================
  localparam csr_addr_t ADDR_MSTATUS   = 12'h300;
  localparam csr_addr_t ADDR_MISA      = 12'h301;
  localparam csr_addr_t ADDR_MIE       = 12'h304;
  localparam csr_addr_t ADDR_MTVEC     = 12'h305;
  localparam csr_addr_t ADDR_MSCRATCH  = 12'h340;
  localparam csr_addr_t ADDR_MEPC      = 12'h341;
  localparam csr_addr_t ADDR_MCAUSE    = 12'h342;
  localparam csr_addr_t ADDR_MTVAL     = 12'h343;
  localparam csr_addr_t ADDR_MIP       = 12'h344;
  localparam csr_addr_t ADDR_MCYCLE    = 12'hB00;
  localparam csr_addr_t ADDR_MINSTRET  = 12'hB02;
  localparam csr_addr_t ADDR_MCYCLEH   = 12'hB80;
  localparam csr_addr_t ADDR_MINSTRETH = 12'hB82;
  localparam csr_addr_t ADDR_CYCLE     = 12'hC00;   // user shadows, read-only
  localparam csr_addr_t ADDR_INSTRET   = 12'hC02;
  localparam csr_addr_t ADDR_CYCLEH    = 12'hC80;
  localparam csr_addr_t ADDR_INSTRETH  = 12'hC82;
  localparam csr_addr_t ADDR_MVENDORID = 12'hF11;
  localparam csr_addr_t ADDR_MARCHID   = 12'hF12;
  localparam csr_addr_t ADDR_MIMPID    = 12'hF13;
  localparam csr_addr_t ADDR_MHARTID   = 12'hF14;

  localparam logic [XLEN-1:0] MTVEC_RESET = 32'h8000_0000;
  localparam logic [XLEN-1:0] VENDOR_ID   = 32'h0000_0000;
  localparam logic [XLEN-1:0] ARCH_ID     = 32'd31;
  localparam logic [XLEN-1:0] IMPL_ID     = 32'h0000_0001;
  // mxl = 1 (rv32), extensions u, m, i, c
  localparam logic [XLEN-1:0] MISA_VALUE  = 32'h4010_1104;

endpackage

`default_nettype wire
